// File: files.f
+incdir+include
logic/phold_pkg.sv
logic/core_bus_if.sv
logic/lfsr.sv
logic/rr_arbiter.sv
logic/sim_ctrl.sv
logic/event_queue.sv
logic/event_dispatch.sv
logic/lp_pool.sv
logic/gvt_calc.sv
logic/phold_top.sv
dv/phold_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f files.f \
   --top-module phold_tb --Mdir obj_dir -o phold_sim
./obj_dir/phold_sim | tee sim.log

if grep -q "^All checks passed$" sim.log; then
   echo "simulation PASS"
else
   echo "simulation FAIL"
   exit 1
fi

// File: dv/phold_tb.sv
`timescale 1ns/10ps
`include "phold_consts.svh"

module phold_tb;
   import phold_pkg::*;

   localparam int NC          = `PHOLD_NUM_CORE;
   localparam int NLP         = `PHOLD_NUM_LP;
   localparam int CLK_PERIOD  = 8;
   localparam int TAIL_CYCLES = 50;
   // ~76 hops per lp chain at up to ~80 cycles each, with about 3x margin
   localparam int WATCHDOG_CYCLES = 20000;

   logic      clk = 1'b0;
   logic      rst_n;
   sim_time_t gvt;
   logic      rtn_vld;
   logic      sent_vld;
   core_id_t  sent_core;
   lp_id_t    sent_lp;
   sim_time_t sent_time;
   logic      recv_vld;
   core_id_t  recv_core;
   lp_id_t    recv_lp;
   sim_time_t recv_time;

   integer seed = 32653;   // no random stimulus, kept for reproducibility

   // scoreboard state
   int            cycle;
   int            sent_count;
   int            recv_count;
   int            last_recv_cycle;
   int            post_cycles;
   int            errors;
   logic [NLP-1:0] init_sent_mask;
   logic [NC-1:0]  outstanding;
   sim_time_t     last_sent_time [NC];
   int            last_sent_cycle [NC];
   sim_time_t     prev_gvt;
   sim_time_t     gvt_at_rtn;
   bit            rtn_seen;
   bit            is_return;
   core_id_t      cidx;

   phold_top u_phold_top (
      .clk       (clk),
      .rst_n     (rst_n),
      .gvt       (gvt),
      .rtn_vld   (rtn_vld),
      .sent_vld  (sent_vld),
      .sent_core (sent_core),
      .sent_lp   (sent_lp),
      .sent_time (sent_time),
      .recv_vld  (recv_vld),
      .recv_core (recv_core),
      .recv_lp   (recv_lp),
      .recv_time (recv_time)
   );

   always #(CLK_PERIOD / 2) clk = ~clk;

   // phold rule: new time = old time + lookahead + 0..15
   function automatic bit delay_in_window(sim_time_t sent_t, sim_time_t recv_t);
      int diff;
      diff = int'(recv_t) - int'(sent_t);
      return (diff >= `PHOLD_MIN_DELAY) &&
             (diff <= `PHOLD_MIN_DELAY + (1 << `PHOLD_DELAY_BITS) - 1);
   endfunction

   // one event in flight per core, set by a send and cleared by its return
   function automatic logic [NC-1:0] next_outstanding(logic [NC-1:0] mask,
                                                      logic s_vld, core_id_t s_core,
                                                      logic r_vld, core_id_t r_core);
      logic [NC-1:0] nxt;
      nxt = mask;
      if (r_vld)
         nxt[r_core] = 1'b0;
      if (s_vld)
         nxt[s_core] = 1'b1;
      return nxt;
   endfunction

   task automatic abort_run(input string msg);
      errors++;
      $display("[FAIL] %0t ns: %s", $time, msg);
      $display("Checks failed");
      $fatal(1, "stopping at first error");
   endtask

   always @(negedge clk) begin
      if (!rst_n) begin
         assert (!rtn_vld && !sent_vld && !recv_vld && gvt == '0)
            else abort_run("outputs not idle during reset");
      end else begin
         cycle++;
         is_return = recv_vld && (recv_count >= NLP);

         assert (!(sent_vld && recv_vld))
            else abort_run("sent and recv strobed in the same cycle");
         assert (gvt >= prev_gvt)
            else abort_run($sformatf("gvt fell from %0d to %0d", prev_gvt, gvt));

         if (rtn_seen) begin   // engine parked
            assert (!rtn_vld) else abort_run("rtn_vld high for more than one cycle");
            assert (!sent_vld && !recv_vld) else abort_run("event traffic after rtn_vld");
            assert (gvt == gvt_at_rtn)
               else abort_run($sformatf("gvt moved to %0d after rtn_vld", gvt));
         end else if (rtn_vld) begin
            assert (gvt > `PHOLD_SIM_END_TIME)
               else abort_run($sformatf("rtn_vld with gvt %0d", gvt));
         end

         if (sent_vld) begin
            cidx = sent_core;
            assert (!outstanding[cidx])
               else abort_run($sformatf("send to busy core %0d", cidx));
            assert (sent_time >= gvt)
               else abort_run($sformatf("sent time %0d below gvt %0d", sent_time, gvt));
            if (sent_count < NLP) begin
               assert (sent_time == '0)
                  else abort_run($sformatf("initial send at time %0d", sent_time));
               assert (!init_sent_mask[sent_lp])
                  else abort_run($sformatf("lp %0d sent twice at time 0", sent_lp));
               init_sent_mask[sent_lp] = 1'b1;
            end
            last_sent_time[cidx]  = sent_time;
            last_sent_cycle[cidx] = cycle;
            sent_count++;
         end

         if (recv_vld && !is_return) begin   // seeding pass
            assert (sent_count == 0) else abort_run("send before seeding finished");
            assert (recv_lp == lp_id_t'(recv_count) && recv_time == '0 && recv_core == '0)
               else abort_run($sformatf("seed %0d came as lp %0d time %0d core %0d",
                                        recv_count, recv_lp, recv_time, recv_core));
            assert (recv_count == 0 || last_recv_cycle == cycle - 1)
               else abort_run("seed events not in consecutive cycles");
         end else if (is_return) begin
            cidx = recv_core;
            assert (outstanding[cidx])
               else abort_run($sformatf("recv from idle core %0d", cidx));
            assert (int'(recv_lp) < NLP)
               else abort_run($sformatf("recv lp %0d out of range", recv_lp));
            assert (delay_in_window(last_sent_time[cidx], recv_time))
               else abort_run($sformatf("core %0d returned time %0d after send at %0d",
                                        cidx, recv_time, last_sent_time[cidx]));
            assert (cycle - last_sent_cycle[cidx] >= `PHOLD_EXEC_CYCLES + 1)
               else abort_run($sformatf("core %0d returned after %0d cycles",
                                        cidx, cycle - last_sent_cycle[cidx]));
         end
         if (recv_vld) begin
            last_recv_cycle = cycle;
            recv_count++;
         end

         outstanding = next_outstanding(outstanding, sent_vld, sent_core,
                                        is_return, recv_core);

         prev_gvt = gvt;
         if (rtn_seen)
            post_cycles++;
         if (rtn_vld && !rtn_seen) begin
            rtn_seen   = 1'b1;
            gvt_at_rtn = gvt;
         end
      end
   end

   initial begin
      cycle          = 0;
      sent_count     = 0;
      recv_count     = 0;
      last_recv_cycle = 0;
      post_cycles    = 0;
      errors         = 0;
      init_sent_mask = '0;
      outstanding    = '0;
      prev_gvt       = '0;
      gvt_at_rtn     = '0;
      rtn_seen       = 1'b0;
      for (int i = 0; i < NC; i++) begin
         last_sent_time[i]  = '0;
         last_sent_cycle[i] = 0;
      end
      $display("phold_tb seed %0d", seed);
      rst_n = 1'b0;
      repeat (2) @(posedge clk);
      rst_n <= 1'b1;
      wait (post_cycles == TAIL_CYCLES);
      if (errors == 0) begin
         $display("All checks passed");
         $finish;
      end else begin
         $display("Checks failed");
         $fatal(1, "%0d errors", errors);
      end
   end

   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      $display("timeout: rtn_vld never arrived within %0d cycles", WATCHDOG_CYCLES);
      $display("Checks failed");
      $fatal(1, "watchdog expired");
   end

endmodule

// File: logic/phold_top.sv
`timescale 1ns/10ps

module phold_top (
   input  logic                 clk,
   input  logic                 rst_n,
   output phold_pkg::sim_time_t gvt,
   output logic                 rtn_vld,
   output logic                 sent_vld,
   output phold_pkg::core_id_t  sent_core,
   output phold_pkg::lp_id_t    sent_lp,
   output phold_pkg::sim_time_t sent_time,
   output logic                 recv_vld,
   output phold_pkg::core_id_t  recv_core,
   output phold_pkg::lp_id_t    recv_lp,
   output phold_pkg::sim_time_t recv_time
);
   import phold_pkg::*;

   sim_state_e  state;
   lp_id_t      init_lp;
   event_msg_t  head;
   logic        empty;
   logic        enq;
   event_msg_t  enq_msg;
   logic        deq;
   logic [15:0] rnd;
   logic        rnd_next;

   core_bus_if u_bus ();

   // prng steps once per initial event and once per dispatch
   assign rnd_next = deq || (state == INIT);

   sim_ctrl u_sim_ctrl (
      .clk     (clk),
      .rst_n   (rst_n),
      .gvt     (gvt),
      .state   (state),
      .init_lp (init_lp),
      .rtn_vld (rtn_vld)
   );

   event_queue u_event_queue (
      .clk     (clk),
      .rst_n   (rst_n),
      .enq     (enq),
      .enq_msg (enq_msg),
      .deq     (deq),
      .head    (head),
      .empty   (empty)
   );

   event_dispatch u_event_dispatch (
      .clk       (clk),
      .rst_n     (rst_n),
      .state     (state),
      .init_lp   (init_lp),
      .head      (head),
      .empty     (empty),
      .enq       (enq),
      .enq_msg   (enq_msg),
      .deq       (deq),
      .bus       (u_bus),
      .sent_vld  (sent_vld),
      .sent_core (sent_core),
      .sent_lp   (sent_lp),
      .sent_time (sent_time),
      .recv_vld  (recv_vld),
      .recv_core (recv_core),
      .recv_lp   (recv_lp),
      .recv_time (recv_time)
   );

   lp_pool u_lp_pool (
      .clk   (clk),
      .rst_n (rst_n),
      .rnd   (rnd),
      .bus   (u_bus)
   );

   lfsr u_lfsr (
      .clk   (clk),
      .rst_n (rst_n),
      .next  (rnd_next),
      .rnd   (rnd)
   );

   gvt_calc u_gvt_calc (
      .clk   (clk),
      .rst_n (rst_n),
      .state (state),
      .head  (head),
      .empty (empty),
      .bus   (u_bus),
      .gvt   (gvt)
   );

endmodule

// File: logic/gvt_calc.sv
`timescale 1ns/10ps
`include "phold_consts.svh"

module gvt_calc (
   input  logic                  clk,
   input  logic                  rst_n,
   input  phold_pkg::sim_state_e state,
   input  phold_pkg::event_msg_t head,
   input  logic                  empty,
   core_bus_if.gvt               bus,
   output phold_pkg::sim_time_t  gvt
);
   import phold_pkg::*;

   localparam int N = `PHOLD_NUM_CORE;

   sim_time_t min_t;
   logic      min_vld;

   // oldest pending time across queue head and in-flight events
   always_comb begin
      min_vld = !empty;
      min_t   = head.ts;
      for (int i = 0; i < N; i++) begin
         if (bus.busy[i] && (!min_vld || bus.busy_time[i] < min_t)) begin
            min_vld = 1'b1;
            min_t   = bus.busy_time[i];
         end
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n)
         gvt <= '0;
      else if (state == RUNNING && min_vld)
         gvt <= min_t;   // frozen outside RUNNING
   end

endmodule

// File: logic/lp_pool.sv
`timescale 1ns/10ps
`include "phold_consts.svh"

module lp_pool (
   input  logic        clk,
   input  logic        rst_n,
   input  logic [15:0] rnd,
   core_bus_if.pool    bus
);
   import phold_pkg::*;

   localparam int N     = `PHOLD_NUM_CORE;
   localparam int LP_W  = $bits(lp_id_t);
   localparam int RND_W = `PHOLD_DELAY_BITS + LP_W;   // increment then target lp
   localparam int CNT_W = $clog2(`PHOLD_EXEC_CYCLES + 1);

   for (genvar g = 0; g < N; g++) begin : gen_core
      core_state_e      cstate;
      logic [CNT_W-1:0] cnt;
      sim_time_t        evt_ts;
      logic [RND_W-1:0] rnd_q;
      event_msg_t       new_msg;
      logic             capture;

      assign capture = (cstate == FREE) && bus.evt_vld[g];

      always_ff @(posedge clk or negedge rst_n) begin
         if (!rst_n) begin
            cstate <= FREE;
            cnt    <= '0;
         end else begin
            case (cstate)
               FREE: begin
                  if (capture) begin
                     cstate <= EXEC;
                     cnt    <= CNT_W'(`PHOLD_EXEC_CYCLES - 1);
                  end
               end
               EXEC: begin
                  if (cnt == '0)
                     cstate <= RETURN;
                  else
                     cnt <= cnt - 1'b1;
               end
               default: begin
                  if (bus.ack[g])
                     cstate <= FREE;   // released the cycle after ack
               end
            endcase
         end
      end

      // event payload, only meaningful while busy
      always_ff @(posedge clk) begin
         if (capture) begin
            evt_ts <= bus.evt_msg.ts;
            rnd_q  <= rnd[RND_W-1:0];
         end
      end

      always_comb begin
         new_msg.lp = rnd_q[`PHOLD_DELAY_BITS +: LP_W];
         new_msg.ts = evt_ts + sim_time_t'(`PHOLD_MIN_DELAY)
                    + sim_time_t'(rnd_q[`PHOLD_DELAY_BITS-1:0]);
      end

      assign bus.ready[g]     = (cstate == FREE);
      assign bus.done[g]      = (cstate == RETURN);
      assign bus.busy[g]      = (cstate != FREE);
      assign bus.out_msg[g]   = new_msg;   // steady until acked
      assign bus.busy_time[g] = evt_ts;
   end

endmodule

// File: logic/event_dispatch.sv
`timescale 1ns/10ps
`include "phold_consts.svh"

module event_dispatch (
   input  logic                  clk,
   input  logic                  rst_n,
   input  phold_pkg::sim_state_e state,
   input  phold_pkg::lp_id_t     init_lp,
   input  phold_pkg::event_msg_t head,
   input  logic                  empty,
   output logic                  enq,
   output phold_pkg::event_msg_t enq_msg,
   output logic                  deq,
   core_bus_if.dispatch          bus,
   output logic                  sent_vld,
   output phold_pkg::core_id_t   sent_core,
   output phold_pkg::lp_id_t     sent_lp,
   output phold_pkg::sim_time_t  sent_time,
   output logic                  recv_vld,
   output phold_pkg::core_id_t   recv_core,
   output phold_pkg::lp_id_t     recv_lp,
   output phold_pkg::sim_time_t  recv_time
);
   import phold_pkg::*;

   localparam int N = `PHOLD_NUM_CORE;

   logic     rdy_vld, done_vld;
   core_id_t rdy_id, done_id;
   logic     enq_run;
   logic     in_init;

   rr_arbiter #(.N(N)) u_send_arb (
      .clk (clk), .rst_n (rst_n), .req (bus.ready), .advance (deq),
      .grant_vld (rdy_vld), .grant_id (rdy_id)
   );

   rr_arbiter #(.N(N)) u_recv_arb (
      .clk (clk), .rst_n (rst_n), .req (bus.done), .advance (enq_run),
      .grant_vld (done_vld), .grant_id (done_id)
   );

   assign in_init = (state == INIT);
   assign enq_run = (state == RUNNING) && done_vld;   // returns win over dispatch
   assign enq     = in_init || enq_run;
   assign deq     = (state == RUNNING) && !enq_run && !empty && rdy_vld;
   assign enq_msg = in_init ? event_msg_t'{lp: init_lp, ts: '0} : bus.out_msg[done_id];

   always_comb begin
      for (int i = 0; i < N; i++) begin
         bus.evt_vld[i] = deq && (rdy_id == core_id_t'(i));
         bus.ack[i]     = enq_run && (done_id == core_id_t'(i));
      end
   end
   assign bus.evt_msg = head;

   assign sent_vld  = deq;
   assign sent_core = rdy_id;
   assign sent_lp   = head.lp;
   assign sent_time = head.ts;
   assign recv_vld  = enq;
   assign recv_core = in_init ? '0 : done_id;   // seeding reported as core 0
   assign recv_lp   = enq_msg.lp;
   assign recv_time = enq_msg.ts;

endmodule

// File: logic/event_queue.sv
`timescale 1ns/10ps
`include "phold_consts.svh"

module event_queue (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  enq,
   input  phold_pkg::event_msg_t enq_msg,
   input  logic                  deq,
   output phold_pkg::event_msg_t head,
   output logic                  empty
);
   import phold_pkg::*;

   localparam int DEPTH = `PHOLD_NUM_LP;

   event_msg_t       q [DEPTH];
   logic [DEPTH-1:0] vld;        // valid entries form a prefix from slot 0
   logic [DEPTH-1:0] ins_here;   // slot will hold new event or a shifted one
   logic [DEPTH-1:0] first;      // exact insert slot

   // strict compare so equal times stay behind older entries
   always_comb begin
      for (int i = 0; i < DEPTH; i++) begin
         ins_here[i] = !vld[i] || (q[i].ts > enq_msg.ts);
      end
   end

   assign first = ins_here & ~{ins_here[DEPTH-2:0], 1'b0};

   always_ff @(posedge clk) begin
      if (enq) begin
         if (ins_here[0])
            q[0] <= enq_msg;
         for (int i = 1; i < DEPTH; i++) begin
            if (first[i])
               q[i] <= enq_msg;
            else if (ins_here[i])
               q[i] <= q[i-1];      // make room
         end
      end else if (deq) begin
         for (int i = 0; i < DEPTH - 1; i++) begin
            q[i] <= q[i+1];
         end
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n)
         vld <= '0;
      else if (enq)
         vld <= {vld[DEPTH-2:0], 1'b1};
      else if (deq)
         vld <= {1'b0, vld[DEPTH-1:1]};
   end

   assign head  = q[0];
   assign empty = !vld[0];

endmodule

// File: logic/sim_ctrl.sv
`timescale 1ns/10ps
`include "phold_consts.svh"

module sim_ctrl (
   input  logic                  clk,
   input  logic                  rst_n,
   input  phold_pkg::sim_time_t  gvt,
   output phold_pkg::sim_state_e state,
   output phold_pkg::lp_id_t     init_lp,
   output logic                  rtn_vld
);
   import phold_pkg::*;

   sim_state_e next_state;
   lp_id_t     init_cnt;

   always_comb begin
      next_state = state;
      case (state)
         IDLE:     next_state = INIT;
         INIT: begin
            if (init_cnt == lp_id_t'(`PHOLD_NUM_LP - 1))
               next_state = READY;    // last lp seeded
         end
         READY:    next_state = RUNNING;
         RUNNING: begin
            if (gvt > `PHOLD_SIM_END_TIME)
               next_state = FINISHED;
         end
         FINISHED: next_state = DONE;
         default:  next_state = DONE;   // parked until reset
      endcase
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state    <= IDLE;
         init_cnt <= '0;
      end else begin
         state    <= next_state;
         init_cnt <= (state == INIT) ? init_cnt + 1'b1 : '0;
      end
   end

   assign init_lp = init_cnt;
   assign rtn_vld = (state == FINISHED);   // single cycle by construction

endmodule

// File: logic/rr_arbiter.sv
`timescale 1ns/10ps

module rr_arbiter #(
   parameter int N = 4
) (
   input  logic                clk,
   input  logic                rst_n,
   input  logic [N-1:0]        req,
   input  logic                advance,
   output logic                grant_vld,
   output phold_pkg::core_id_t grant_id
);
   import phold_pkg::*;

   core_id_t last;   // previous winner

   always_comb begin
      int idx;
      grant_vld = 1'b0;
      grant_id  = '0;
      for (int i = 1; i <= N; i++) begin
         idx = (int'(last) + i) % N;
         if (!grant_vld && req[idx]) begin
            grant_vld = 1'b1;
            grant_id  = core_id_t'(idx);
         end
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n)
         last <= core_id_t'(N - 1);   // core 0 first after reset
      else if (advance)
         last <= grant_id;
   end

endmodule

// File: logic/lfsr.sv
`timescale 1ns/10ps
`include "phold_consts.svh"

module lfsr (
   input  logic        clk,
   input  logic        rst_n,
   input  logic        next,
   output logic [15:0] rnd
);

   // x^16 + x^14 + x^13 + x^11 + 1, right-shifting galois form
   localparam logic [15:0] TAPS = 16'hB400;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n)
         rnd <= `PHOLD_LFSR_SEED;
      else if (next)
         rnd <= {1'b0, rnd[15:1]} ^ (rnd[0] ? TAPS : 16'h0000);
   end

endmodule

// File: logic/core_bus_if.sv
`timescale 1ns/10ps
`include "phold_consts.svh"

interface core_bus_if;
   import phold_pkg::*;

   localparam int N = `PHOLD_NUM_CORE;

   logic [N-1:0]       evt_vld;    // dispatch strobe per core
   event_msg_t         evt_msg;    // shared by all cores
   logic [N-1:0]       ready;
   logic [N-1:0]       done;
   event_msg_t [N-1:0] out_msg;
   logic [N-1:0]       ack;
   logic [N-1:0]       busy;
   sim_time_t [N-1:0]  busy_time;

   modport dispatch (output evt_vld, evt_msg, ack,
                     input  ready, done, out_msg);

   modport pool (input  evt_vld, evt_msg, ack,
                 output ready, done, out_msg, busy, busy_time);

   // min-time tap for the gvt logic
   modport gvt (input busy, busy_time);

endinterface

// File: logic/phold_pkg.sv
`include "phold_consts.svh"

package phold_pkg;

   typedef logic [`PHOLD_TIME_WID-1:0] sim_time_t;
   typedef logic [$clog2(`PHOLD_NUM_LP)-1:0] lp_id_t;
   typedef logic [$clog2(`PHOLD_NUM_CORE)-1:0] core_id_t;

   // target lp in the upper bits, timestamp below
   typedef struct packed {
      lp_id_t    lp;
      sim_time_t ts;
   } event_msg_t;

   typedef enum logic [2:0] {
      IDLE, INIT, READY, RUNNING, FINISHED, DONE
   } sim_state_e;

   typedef enum logic [1:0] {
      FREE, EXEC, RETURN
   } core_state_e;

endpackage

// File: include/phold_consts.svh
`ifndef PHOLD_CONSTS_SVH
`define PHOLD_CONSTS_SVH

// engine sizing
`define PHOLD_NUM_CORE      4
`define PHOLD_NUM_LP        16     // also the queue depth
`define PHOLD_TIME_WID      16

// event generation
`define PHOLD_MIN_DELAY     4      // lookahead
`define PHOLD_DELAY_BITS    4      // random increment 0..15
`define PHOLD_EXEC_CYCLES   3

// run control
`define PHOLD_SIM_END_TIME  300
`define PHOLD_LFSR_SEED     16'hACE1

`endif
